/* spi_layer.f */
hdl/spi_cfg_pkg.sv
hdl/spi_bus_pkg.sv
hdl/afifo_gray.sv
hdl/spi_shifter.sv
hdl/spi_bus_ctrl.sv
hdl/spi_status_flags.sv
hdl/spi_layer.sv
test/tb_spi_layer.sv

/* Bender.yml */
package:
  name: spi_layer

sources:
  - files:
      - hdl/spi_cfg_pkg.sv
      - hdl/spi_bus_pkg.sv
      - hdl/afifo_gray.sv
      - hdl/spi_shifter.sv
      - hdl/spi_bus_ctrl.sv
      - hdl/spi_status_flags.sv
      - hdl/spi_layer.sv
  - target: test
    files:
      - test/tb_spi_layer.sv

/* test/tb_spi_layer.sv */
`timescale 1ns/1ps

module tb_spi_layer;

   import spi_cfg_pkg::*;
   import spi_bus_pkg::*;

   // Run limit in clk_i cycles.
   // Roughly three times all tests together.
   localparam int TIMEOUT_CYCLES = 4000;
   // Bound on polls of synchronised levels.
   localparam int POLL_CYCLES    = 32;
   // Half an sck_i period in clk_i cycles. One SPI bit takes 64 ns.
   localparam int SCK_HALF       = 4;
   localparam logic [15:0] LFSR_SEED = 16'd41067;

   logic              clk_i;
   logic              SSEL;
   logic              sck_i;
   logic              mosi_i;
   logic              miso_o;
   logic              rdy_i;
   logic              ack_i;
   logic [BYTE_W-1:0] dat_i;
   logic [BYTE_W-1:0] dat_o;
   bus_req_t          bus_o;
   spi_status_t       status_o;

   logic [15:0]       lfsr_q;
   int                cycle_cnt;

   // MOSI bytes, MISO bytes seen, and bytes given in answer to get.
   logic [BYTE_W-1:0] mosi_q [$];
   logic [BYTE_W-1:0] miso_q [$];
   logic [BYTE_W-1:0] tx_q   [$];

   spi_layer u_dut (
      .clk_i    (clk_i),
      .SSEL     (SSEL),
      .sck_i    (sck_i),
      .mosi_i   (mosi_i),
      .miso_o   (miso_o),
      .rdy_i    (rdy_i),
      .ack_i    (ack_i),
      .dat_i    (dat_i),
      .dat_o    (dat_o),
      .bus_o    (bus_o),
      .status_o (status_o)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_failure("Run did not finish within the cycle limit");
      end
   end

   //----------------------------------------------------------------------
   // Reporting and compare tasks.
   //----------------------------------------------------------------------

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_byte(input string name, input logic [BYTE_W-1:0] got,
                             input logic [BYTE_W-1:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bus(input string name, input bus_req_t got, input bus_req_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_status(input string name, input spi_status_t got,
                               input spi_status_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   //----------------------------------------------------------------------
   // Stimulus data.
   //----------------------------------------------------------------------

   // Fibonacci LFSR with taps 16 14 13 11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken.
   task automatic draw_byte(output logic [BYTE_W-1:0] b);
      for (int i = 0; i < BYTE_W; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         b = {b[BYTE_W-2:0], lfsr_q[0]};
      end
   endtask

   task automatic fill_queues(input int n);
      logic [BYTE_W-1:0] b;
      mosi_q.delete();
      miso_q.delete();
      tx_q.delete();
      for (int k = 0; k < n; k++) begin
         draw_byte(b);
         mosi_q.push_back(b);
         draw_byte(b);
         tx_q.push_back(b);
      end
   endtask

   //----------------------------------------------------------------------
   // Bounded polls. Values are read just after the clock edge.
   //----------------------------------------------------------------------

   task automatic wait_cyc(input logic level);
      int n;
      n = 0;
      @(posedge clk_i);
      while (bus_o.cyc !== level) begin
         n++;
         if (n > POLL_CYCLES) begin
            stop_with_failure($sformatf("cyc never reached %0b after a select change", level));
         end
         @(posedge clk_i);
      end
   endtask

   task automatic wait_rx_ready();
      int n;
      n = 0;
      @(posedge clk_i);
      while (bus_o.wat !== 1'b0) begin
         n++;
         if (n > POLL_CYCLES) begin
            stop_with_failure("No received byte showed up at dat_o");
         end
         @(posedge clk_i);
      end
   endtask

   task automatic wait_any_flag();
      int n;
      n = 0;
      @(posedge clk_i);
      while (status_o === '0) begin
         n++;
         if (n > POLL_CYCLES) begin
            stop_with_failure("No status flag was set after the error event");
         end
         @(posedge clk_i);
      end
   endtask

   //----------------------------------------------------------------------
   // SPI master and bus responder.
   //----------------------------------------------------------------------

   task automatic frame_begin();
      @(posedge clk_i);
      SSEL <= 1'b0;
      wait_cyc(1'b1);
   endtask

   task automatic frame_end();
      @(posedge clk_i);
      SSEL <= 1'b1;
      wait_cyc(1'b0);
   endtask

   // SPI mode 0. MOSI moves on the falling sck edge and MISO is taken on the rising one.
   task automatic spi_bytes(input int n);
      logic [BYTE_W-1:0] rx;
      for (int k = 0; k < n; k++) begin
         for (int i = BYTE_W - 1; i >= 0; i--) begin
            @(posedge clk_i);
            sck_i  <= 1'b0;
            mosi_i <= mosi_q[k][i];
            repeat (SCK_HALF) @(posedge clk_i);
            rx[i]  = miso_o;
            sck_i  <= 1'b1;
            repeat (SCK_HALF - 1) @(posedge clk_i);
         end
         miso_q.push_back(rx);
      end
      // Closing falling edge of the frame.
      @(posedge clk_i);
      sck_i <= 1'b0;
      repeat (SCK_HALF - 1) @(posedge clk_i);
   endtask

   // One rdy strobe per get carries the next byte of tx_q.
   task automatic answer_gets(input int n);
      for (int k = 0; k < n; k++) begin
         @(posedge clk_i);
         while (!bus_o.get) begin
            @(posedge clk_i);
         end
         rdy_i <= 1'b1;
         dat_i <= tx_q[k];
         @(posedge clk_i);
         rdy_i <= 1'b0;
      end
   endtask

   // Pop n bytes and compare them with what went out on MOSI.
   task automatic drain_rx(input int n);
      for (int k = 0; k < n; k++) begin
         wait_rx_ready();
         check_byte($sformatf("dat_o[%0d]", k), dat_o, mosi_q[k]);
         ack_i <= 1'b1;
         @(posedge clk_i);
         ack_i <= 1'b0;
      end
   endtask

   //----------------------------------------------------------------------
   // Directed tests.
   //----------------------------------------------------------------------

   task automatic reset_defaults();
      @(posedge clk_i);
      check_bus("bus_o", bus_o, bus_req_t'{cyc: 1'b0, get: 1'b0, wat: 1'b1});
      check_status("status_o", status_o, '0);
      check_bit("miso_o", miso_o, HEADER_BYTE[BYTE_W-1]);
   endtask

   task automatic select_tracking();
      frame_begin();
      check_bus("bus_o", bus_o, bus_req_t'{cyc: 1'b1, get: 1'b0, wat: 1'b1});
      frame_end();
      check_bus("bus_o", bus_o, bus_req_t'{cyc: 1'b0, get: 1'b0, wat: 1'b1});
   endtask

   // MISO carries the header and then the answered bytes.
   // RX bytes come back in order.
   task automatic frame_transfer();
      fill_queues(5);
      frame_begin();
      fork
         spi_bytes(5);
         answer_gets(5);
      join
      check_byte("miso byte 0", miso_q[0], HEADER_BYTE);
      for (int k = 1; k < 5; k++) begin
         check_byte($sformatf("miso byte %0d", k), miso_q[k], tx_q[k-1]);
      end
      drain_rx(5);
      @(posedge clk_i);
      check_bus("bus_o", bus_o, bus_req_t'{cyc: 1'b1, get: 1'b0, wat: 1'b1});
      check_status("status_o", status_o, '0);
      frame_end();
   endtask

   // Without any rdy the first pull finds the TX FIFO empty.
   task automatic underrun_recovery();
      fill_queues(2);
      frame_begin();
      spi_bytes(2);
      wait_any_flag();
      check_status("status_o", status_o, spi_status_t'{overflow: 1'b0, underrun: 1'b1});
      frame_end();
      frame_begin();
      check_status("status_o", status_o, '0);
      frame_end();
   endtask

   // The last of seventeen bytes is dropped by the sixteen deep FIFO.
   task automatic overflow_readback();
      fill_queues(17);
      frame_begin();
      fork
         spi_bytes(17);
         answer_gets(17);
      join
      wait_any_flag();
      check_status("status_o", status_o, spi_status_t'{overflow: 1'b1, underrun: 1'b0});
      drain_rx(FIFO_DEPTH);
      @(posedge clk_i);
      check_bus("bus_o", bus_o, bus_req_t'{cyc: 1'b1, get: 1'b0, wat: 1'b1});
      frame_end();
   endtask

   initial begin
      clk_i     = 1'b0;
      SSEL      = 1'b1;
      sck_i     = 1'b0;
      mosi_i    = 1'b0;
      rdy_i     = 1'b0;
      ack_i     = 1'b0;
      dat_i     = '0;
      lfsr_q    = LFSR_SEED;
      cycle_cnt = 0;
      // Deselected frame doubles as reset.
      repeat (10) @(posedge clk_i);
      reset_defaults();
      select_tracking();
      frame_transfer();
      underrun_recovery();
      overflow_readback();
      $display("test passed");
      $finish;
   end

endmodule : tb_spi_layer

/* hdl/spi_layer.sv */
`timescale 1ns/1ps

module spi_layer (
   input  logic                           clk_i,
   input  logic                           SSEL,
   input  logic                           sck_i,
   input  logic                           mosi_i,
   output logic                           miso_o,
   input  logic                           rdy_i,
   input  logic                           ack_i,
   input  logic [spi_cfg_pkg::BYTE_W-1:0] dat_i,
   output logic [spi_cfg_pkg::BYTE_W-1:0] dat_o,
   output spi_bus_pkg::bus_req_t          bus_o,
   output spi_bus_pkg::spi_status_t       status_o
);

   import spi_cfg_pkg::*;
   import spi_bus_pkg::*;

   // TX FIFO reads on falling sck edges, with the serialiser.
   logic              sck_n;

   logic [BYTE_W-1:0] tx_data;
   logic [BYTE_W-1:0] rx_data;
   logic              tx_pull;
   logic              tx_empty;
   logic              rx_push;
   logic              rx_full;
   logic              rx_empty;
   spi_evt_t          evt;

   assign sck_n = ~sck_i;

   //--------------------------------------------------------------------
   // SPI domain.
   //--------------------------------------------------------------------

   spi_shifter u_shifter (
      .sck_i      (sck_i),
      .SSEL       (SSEL),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .tx_data_i  (tx_data),
      .tx_empty_i (tx_empty),
      .rx_full_i  (rx_full),
      .tx_pull_o  (tx_pull),
      .rx_push_o  (rx_push),
      .rx_data_o  (rx_data),
      .evt_o      (evt)
   );

   //--------------------------------------------------------------------
   // Clock-crossing FIFOs.
   //--------------------------------------------------------------------

   // Bus writes, SPI reads.
   afifo_gray u_tx_fifo (
      .wr_clk_i  (clk_i),
      .wr_en_i   (rdy_i),
      .wr_data_i (dat_i),
      .wfull_o   (),
      .rd_clk_i  (sck_n),
      .rd_en_i   (tx_pull),
      .rd_data_o (tx_data),
      .rempty_o  (tx_empty),
      .SSEL      (SSEL)
   );

   // SPI writes, bus reads.
   afifo_gray u_rx_fifo (
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_data),
      .wfull_o   (rx_full),
      .rd_clk_i  (clk_i),
      .rd_en_i   (ack_i),
      .rd_data_o (dat_o),
      .rempty_o  (rx_empty),
      .SSEL      (SSEL)
   );

   //--------------------------------------------------------------------
   // Bus domain.
   //--------------------------------------------------------------------

   spi_bus_ctrl u_bus_ctrl (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .req_tgl_i  (evt.req_tgl),
      .rdy_i      (rdy_i),
      .rx_empty_i (rx_empty),
      .bus_o      (bus_o)
   );

   spi_status_flags u_status (
      .clk_i     (clk_i),
      .SSEL      (SSEL),
      .ovf_tgl_i (evt.ovf_tgl),
      .unf_tgl_i (evt.unf_tgl),
      .status_o  (status_o)
   );

endmodule : spi_layer

/* hdl/spi_status_flags.sv */
`timescale 1ns/1ps

module spi_status_flags (
   input  logic                     clk_i,
   input  logic                     SSEL,
   input  logic                     ovf_tgl_i,
   input  logic                     unf_tgl_i,
   output spi_bus_pkg::spi_status_t status_o
);

   // Bit 1 carries overflow, bit 0 underrun.
   logic [1:0] tgl_sync1_q;
   logic [1:0] tgl_sync2_q;
   logic [1:0] tgl_last_q;
   logic [1:0] tgl_evt_q;
   logic [1:0] flag_q;

   //--------------------------------------------------------------------
   // Toggle crossing and sticky flags.
   //--------------------------------------------------------------------

   // Two synchroniser stages, an edge register, then the flags.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         tgl_sync1_q <= '0;
         tgl_sync2_q <= '0;
         tgl_last_q  <= '0;
         tgl_evt_q   <= '0;
         flag_q      <= '0;
      end else begin
         tgl_sync1_q <= {ovf_tgl_i, unf_tgl_i};
         tgl_sync2_q <= tgl_sync1_q;
         tgl_last_q  <= tgl_sync2_q;
         tgl_evt_q   <= tgl_sync2_q ^ tgl_last_q;
         // Set only, cleared by the next deselect.
         flag_q      <= flag_q | tgl_evt_q;
      end
   end

   assign status_o = '{overflow: flag_q[1], underrun: flag_q[0]};

endmodule : spi_status_flags

/* hdl/spi_bus_ctrl.sv */
`timescale 1ns/1ps

module spi_bus_ctrl (
   input  logic                  clk_i,
   input  logic                  SSEL,
   input  logic                  req_tgl_i,
   input  logic                  rdy_i,
   input  logic                  rx_empty_i,
   output spi_bus_pkg::bus_req_t bus_o
);

   import spi_bus_pkg::*;

   // Select level in the bus domain.
   logic         ssel_q1;
   logic         ssel_q2;
   logic         cyc_q;

   // Prefetch request crossing.
   logic [1:0]   req_sync_q;
   logic         req_last_q;
   logic         req_evt_q;

   fetch_state_e state_q;
   fetch_state_e state_d;

   //--------------------------------------------------------------------
   // Frame tracking.
   //--------------------------------------------------------------------

   // Two-flop synchroniser of the select line.
   // cyc needs both stages low, so it drops on the first stage.
   always_ff @(posedge clk_i) begin
      ssel_q1 <= SSEL;
      ssel_q2 <= ssel_q1;
      cyc_q   <= !ssel_q1 && !ssel_q2;
   end

   //--------------------------------------------------------------------
   // Prefetch requests.
   //--------------------------------------------------------------------

   // Toggle synchroniser, then a registered edge pulse.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         req_sync_q <= '0;
         req_last_q <= 1'b0;
         req_evt_q  <= 1'b0;
      end else begin
         req_sync_q <= {req_sync_q[0], req_tgl_i};
         req_last_q <= req_sync_q[1];
         req_evt_q  <= req_sync_q[1] ^ req_last_q;
      end
   end

   // Requests arriving while get is pending merge into it.
   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH_IDLE: begin
            if (req_evt_q) begin
               state_d = FETCH_PEND;
            end
         end
         FETCH_PEND: begin
            if (rdy_i && !req_evt_q) begin
               state_d = FETCH_IDLE;
            end
         end
         default: state_d = FETCH_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state_q <= FETCH_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign bus_o = '{cyc: cyc_q, get: (state_q == FETCH_PEND), wat: rx_empty_i};

   // The bus answers only a pending get or inside a frame.
   rdy_in_frame_a : assert property (
      @(posedge clk_i) disable iff (SSEL) rdy_i |-> (bus_o.get || bus_o.cyc)
   );

   // A prefetch never starts before the frame is seen here.
   get_in_frame_a : assert property (
      @(posedge clk_i) disable iff (SSEL) $rose(bus_o.get) |-> bus_o.cyc
   );

endmodule : spi_bus_ctrl

/* hdl/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter (
   input  logic                           sck_i,
   input  logic                           SSEL,
   input  logic                           mosi_i,
   output logic                           miso_o,
   input  logic [spi_cfg_pkg::BYTE_W-1:0] tx_data_i,
   input  logic                           tx_empty_i,
   input  logic                           rx_full_i,
   output logic                           tx_pull_o,
   output logic                           rx_push_o,
   output logic [spi_cfg_pkg::BYTE_W-1:0] rx_data_o,
   output spi_bus_pkg::spi_evt_t          evt_o
);

   import spi_cfg_pkg::*;

   // Bit counters, one per clock edge.
   logic [BIT_CNT_W-1:0] rx_cnt_q;
   logic [BIT_CNT_W-1:0] tx_cnt_q;

   // Shift registers, seven bits each.
   logic [BYTE_W-2:0]    rx_sr_q;
   logic [BYTE_W-2:0]    tx_sr_q;

   logic                 rx_last;
   logic                 tx_last;

   // Event toggles.
   logic                 ovf_tgl_q;
   logic                 unf_tgl_q;
   logic                 req_tgl_q;

   //--------------------------------------------------------------------
   // Receive, on rising sck edges.
   //--------------------------------------------------------------------

   assign rx_last = (rx_cnt_q == BIT_CNT_W'(BYTE_W - 1));

   // The current MOSI bit completes the byte, MSB first.
   assign rx_data_o = {rx_sr_q, mosi_i};

   // A byte arriving at a full FIFO is dropped.
   assign rx_push_o = rx_last && !rx_full_i;

   always_ff @(posedge sck_i) begin
      rx_sr_q <= {rx_sr_q[BYTE_W-3:0], mosi_i};
   end

   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         rx_cnt_q  <= '0;
         ovf_tgl_q <= 1'b0;
         req_tgl_q <= 1'b0;
      end else begin
         rx_cnt_q <= rx_cnt_q + BIT_CNT_W'(1);
         // First bit of a byte, ask the bus for the next TX byte.
         if (rx_cnt_q == '0) begin
            req_tgl_q <= !req_tgl_q;
         end
         if (rx_last && rx_full_i) begin
            ovf_tgl_q <= !ovf_tgl_q;
         end
      end
   end

   //--------------------------------------------------------------------
   // Transmit, on falling sck edges.
   //--------------------------------------------------------------------

   assign tx_last = (tx_cnt_q == BIT_CNT_W'(BYTE_W - 1));

   // Header leaves first, then the FIFO head at each byte boundary.
   // The pop follows one falling edge later.
   // So the final byte of a frame never drains an extra word.
   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         tx_cnt_q  <= '0;
         tx_sr_q   <= HEADER_BYTE[BYTE_W-2:0];
         miso_o    <= HEADER_BYTE[BYTE_W-1];
         tx_pull_o <= 1'b0;
         unf_tgl_q <= 1'b0;
      end else begin
         tx_cnt_q  <= tx_cnt_q + BIT_CNT_W'(1);
         tx_pull_o <= tx_last;
         if (tx_last) begin
            miso_o  <= tx_data_i[BYTE_W-1];
            tx_sr_q <= tx_data_i[BYTE_W-2:0];
         end else begin
            miso_o  <= tx_sr_q[BYTE_W-2];
            tx_sr_q <= {tx_sr_q[BYTE_W-3:0], 1'b0};
         end
         // Pulling from an empty FIFO.
         if (tx_pull_o && tx_empty_i) begin
            unf_tgl_q <= !unf_tgl_q;
         end
      end
   end

   assign evt_o = '{ovf_tgl: ovf_tgl_q, unf_tgl: unf_tgl_q, req_tgl: req_tgl_q};

endmodule : spi_shifter

/* hdl/afifo_gray.sv */
`timescale 1ns/1ps

module afifo_gray (
   input  logic                           wr_clk_i,
   input  logic                           wr_en_i,
   input  logic [spi_cfg_pkg::BYTE_W-1:0] wr_data_i,
   output logic                           wfull_o,
   input  logic                           rd_clk_i,
   input  logic                           rd_en_i,
   output logic [spi_cfg_pkg::BYTE_W-1:0] rd_data_o,
   output logic                           rempty_o,
   input  logic                           SSEL
);

   import spi_cfg_pkg::*;

   // Storage array.
   logic [BYTE_W-1:0]   mem [FIFO_DEPTH];

   // Write side pointers.
   logic [FIFO_ABITS:0] wbin_q;
   logic [FIFO_ABITS:0] wgray_q;
   logic [FIFO_ABITS:0] wbin_nxt;

   // Read side pointers.
   logic [FIFO_ABITS:0] rbin_q;
   logic [FIFO_ABITS:0] rgray_q;
   logic [FIFO_ABITS:0] rbin_nxt;

   // Gray pointers seen through the other domain's synchroniser.
   logic [FIFO_ABITS:0] wq1_rgray_q;
   logic [FIFO_ABITS:0] wq2_rgray_q;
   logic [FIFO_ABITS:0] rq1_wgray_q;
   logic [FIFO_ABITS:0] rq2_wgray_q;

   logic                wr_ok;
   logic                rd_ok;

   //--------------------------------------------------------------------
   // Write domain.
   //--------------------------------------------------------------------

   // A write while full is ignored.
   assign wr_ok    = wr_en_i && !wfull_o;
   assign wbin_nxt = wbin_q + (FIFO_ABITS + 1)'(1);

   always_ff @(posedge wr_clk_i) begin
      if (wr_ok) begin
         mem[wbin_q[FIFO_ABITS-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge wr_clk_i or posedge SSEL) begin
      if (SSEL) begin
         wbin_q      <= '0;
         wgray_q     <= '0;
         wq1_rgray_q <= '0;
         wq2_rgray_q <= '0;
      end else begin
         wq1_rgray_q <= rgray_q;
         wq2_rgray_q <= wq1_rgray_q;
         if (wr_ok) begin
            wbin_q  <= wbin_nxt;
            wgray_q <= (wbin_nxt >> 1) ^ wbin_nxt;
         end
      end
   end

   // Full when the pointers differ only in the two top Gray bits.
   assign wfull_o = (wgray_q == {~wq2_rgray_q[FIFO_ABITS:FIFO_ABITS-1],
                                 wq2_rgray_q[FIFO_ABITS-2:0]});

   //--------------------------------------------------------------------
   // Read domain.
   //--------------------------------------------------------------------

   // A read while empty leaves the pointer where it is.
   // The consumer flags the underrun itself.
   assign rd_ok    = rd_en_i && !rempty_o;
   assign rbin_nxt = rbin_q + (FIFO_ABITS + 1)'(1);

   always_ff @(posedge rd_clk_i or posedge SSEL) begin
      if (SSEL) begin
         rbin_q      <= '0;
         rgray_q     <= '0;
         rq1_wgray_q <= '0;
         rq2_wgray_q <= '0;
      end else begin
         rq1_wgray_q <= wgray_q;
         rq2_wgray_q <= rq1_wgray_q;
         if (rd_ok) begin
            rbin_q  <= rbin_nxt;
            rgray_q <= (rbin_nxt >> 1) ^ rbin_nxt;
         end
      end
   end

   // First-word-fall-through head of the queue.
   assign rd_data_o = mem[rbin_q[FIFO_ABITS-1:0]];
   assign rempty_o  = (rgray_q == rq2_wgray_q);

   // The producer on the far side must watch the full flag.
   wr_not_full_a : assert property (
      @(posedge wr_clk_i) disable iff (SSEL) wr_en_i |-> !wfull_o
   );

endmodule : afifo_gray

/* hdl/spi_bus_pkg.sv */
package spi_bus_pkg;

   //--------------------------------------------------------------------
   // Bus-side control types.
   //--------------------------------------------------------------------

   // Prefetch state.
   // PEND holds get high until the bus answers with rdy.
   typedef enum logic {
      FETCH_IDLE = 1'b0,
      FETCH_PEND = 1'b1
   } fetch_state_e;

   // Bus-master request lines.
   // cyc frames the transfer, get asks for one TX byte.
   // wat is high while no received byte is waiting.
   typedef struct packed {
      logic cyc;
      logic get;
      logic wat;
   } bus_req_t;

   // Sticky error flags, cleared only by SSEL.
   typedef struct packed {
      logic overflow;
      logic underrun;
   } spi_status_t;

   //--------------------------------------------------------------------
   // SPI-domain events.
   //--------------------------------------------------------------------

   // Each event flips its bit, so a slow domain sees every one as an edge.
   typedef struct packed {
      logic ovf_tgl;
      logic unf_tgl;
      logic req_tgl;
   } spi_evt_t;

endpackage : spi_bus_pkg

/* hdl/spi_cfg_pkg.sv */
package spi_cfg_pkg;

   //--------------------------------------------------------------------
   // SPI frame format.
   //--------------------------------------------------------------------

   // Bits per SPI word.
   // Only whole bytes are carried.
   localparam int BYTE_W = 8;

   // Bit counter width.
   // It wraps once per word.
   localparam int BIT_CNT_W = 3;

   // First MISO byte of every frame.
   // The master can use it to check that the slave is present.
   localparam logic [BYTE_W-1:0] HEADER_BYTE = 8'hA7;

   //--------------------------------------------------------------------
   // FIFO sizing.
   //--------------------------------------------------------------------

   // Address bits of both clock-crossing FIFOs.
   // Pointers carry one extra wrap bit.
   localparam int FIFO_ABITS = 4;

   // Words held by each FIFO.
   localparam int FIFO_DEPTH = 1 << FIFO_ABITS;

endpackage : spi_cfg_pkg
